//--- logic/isaPkg.sv
package isaPkg;

    typedef enum logic [6:0] {
        opOp     = 7'b0110011,  // Register-register arithmetic
        opOpImm  = 7'b0010011,  // Register-immediate arithmetic
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    // Branch compares
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // OP and OP-IMM functions
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcodeT     opcode;
    } bTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        opcodeT     opcode;
    } jTypeT;

    // One fetched word, seen through each instruction format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        bTypeT bType;
        jTypeT jType;
    } instrT;

endpackage

//--- logic/corePkg.sv
package corePkg;

    typedef enum logic [1:0] {
        pcPlusFour = 2'd0,
        pcJal      = 2'd1,
        pcBranch   = 2'd2
    } pcSourceT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        cmpEq,   // Compares give 0 or 1
        cmpNe,
        cmpLt,
        cmpGe,
        cmpLtu,
        cmpGeu
    } aluOpT;

    typedef struct packed {
        logic        valid;
        logic [15:0] wordAddress;
        logic [31:0] data;
    } progLoadT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic [31:0] rs1Value;
        logic [31:0] rs2Value;
        logic        writeEnable;
        logic [4:0]  rd;
        logic [31:0] writeData;
    } retireT;

endpackage

//--- logic/instructionMemory.sv
`timescale 1ns/1ns

module instructionMemory #(
    parameter int programWords = 64
) (
    input  logic              clk,
    input  corePkg::progLoadT progLoad,
    input  logic [31:0]       pc,
    output isaPkg::instrT     instr
);

    localparam int addrBits = $clog2(programWords);

    logic [31:0] memory [programWords];

    // Empty program decodes as no-ops
    initial begin
        for (int i = 0; i < programWords; i++) begin
            memory[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (progLoad.valid) begin
            memory[progLoad.wordAddress[addrBits-1:0]] <= progLoad.data;  // Address wraps
        end
    end

    assign instr = memory[pc[addrBits+1:2]];  // Word fetch, byte offset dropped

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic        clk,
    input  logic        reset,
    input  logic        writeEnable,
    input  logic [4:0]  rd,
    input  logic [31:0] writeData,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1Value,
    output logic [31:0] rs2Value
);

    logic [31:0] registers [1:31];  // No storage behind x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && rd != 5'd0) begin
            registers[rd] <= writeData;
        end
    end

    // Old value visible during the writing cycle
    always_comb begin
        rs1Value = '0;
        rs2Value = '0;
        if (rs1 != 5'd0) begin
            rs1Value = registers[rs1];
        end
        if (rs2 != 5'd0) begin
            rs2Value = registers[rs2];
        end
    end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
    input  corePkg::aluOpT aluOp,
    input  logic [31:0]    operandA,
    input  logic [31:0]    operandB,
    output logic [31:0]    result
);

    import corePkg::*;

    logic [4:0] shiftAmount;
    logic       lessSigned;
    logic       lessUnsigned;
    logic       equal;

    assign shiftAmount  = operandB[4:0];
    assign lessSigned   = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;
    assign equal        = operandA == operandB;

    always_comb begin
        case (aluOp)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = operandA - operandB;
            aluSll:  result = operandA << shiftAmount;
            aluSlt:  result = {31'b0, lessSigned};
            aluSltu: result = {31'b0, lessUnsigned};
            aluXor:  result = operandA ^ operandB;
            aluSrl:  result = operandA >> shiftAmount;
            aluSra:  result = $unsigned($signed(operandA) >>> shiftAmount);  // Sign fill
            aluOr:   result = operandA | operandB;
            aluAnd:  result = operandA & operandB;
            // Branch conditions land in bit 0
            cmpEq:   result = {31'b0, equal};
            cmpNe:   result = {31'b0, !equal};
            cmpLt:   result = {31'b0, lessSigned};
            cmpGe:   result = {31'b0, !lessSigned};
            cmpLtu:  result = {31'b0, lessUnsigned};
            cmpGeu:  result = {31'b0, !lessUnsigned};
            default: result = '0;
        endcase
    end

endmodule

//--- logic/decoder.sv
`timescale 1ns/1ns

module decoder (
    input  isaPkg::instrT     instr,
    input  logic [31:0]       aluResult,
    output corePkg::aluOpT    aluOp,
    output logic              useImmediate,
    output logic [31:0]       immediate,
    output logic              writeEnable,
    output logic              isJal,
    output corePkg::pcSourceT pcSource
);

    import isaPkg::*;
    import corePkg::*;

    // Shared by OP and OP-IMM with alt from instruction bit 30
    function automatic aluOpT arithOp(input logic [2:0] funct3, input logic alt,
                                      input logic allowSub);
        aluOpT op;
        case (funct3)
            f3AddSub: op = (alt && allowSub) ? aluSub : aluAdd;
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3SrlSra: op = alt ? aluSra : aluSrl;
            f3Or:     op = aluOr;
            default:  op = aluAnd;
        endcase
        return op;
    endfunction

    assign immediate = {{20{instr.iType.imm[11]}}, instr.iType.imm};

    always_comb begin
        logic writesRd;
        writesRd     = 1'b0;
        aluOp        = aluAdd;
        useImmediate = 1'b0;
        isJal        = 1'b0;
        pcSource     = pcPlusFour;
        case (instr.rType.opcode)
            opOp: begin
                writesRd = 1'b1;
                aluOp    = arithOp(instr.rType.funct3, instr.rType.funct7[5], 1'b1);
            end
            opOpImm: begin
                writesRd     = 1'b1;
                useImmediate = 1'b1;
                aluOp        = arithOp(instr.iType.funct3, instr.rType.funct7[5], 1'b0);
            end
            opBranch: begin
                case (instr.bType.funct3)
                    f3Beq:   aluOp = cmpEq;
                    f3Bne:   aluOp = cmpNe;
                    f3Blt:   aluOp = cmpLt;
                    f3Bge:   aluOp = cmpGe;
                    f3Bltu:  aluOp = cmpLtu;
                    f3Bgeu:  aluOp = cmpGeu;
                    default: aluOp = aluAnd;  // Reserved funct3
                endcase
                // Reserved codes 010 and 011 never branch
                if (aluResult[0] && instr.bType.funct3[2:1] != 2'b01) begin
                    pcSource = pcBranch;
                end
            end
            opJal: begin
                writesRd = 1'b1;
                isJal    = 1'b1;
                pcSource = pcJal;
            end
            default: ;  // Everything else is a no-op
        endcase
        writeEnable = writesRd && instr.rType.rd != 5'd0;
    end

endmodule

//--- logic/nextPc.sv
`timescale 1ns/1ns

module nextPc #(
    parameter int programWords = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  isaPkg::instrT     instr,
    input  corePkg::pcSourceT pcSource,
    output logic [31:0]       pc,
    output logic [31:0]       pcPlusFour
);

    import corePkg::*;

    localparam logic [31:0] pcMask = 32'(programWords * 4 - 1);  // Byte range of memory

    logic [31:0] jalOffset;
    logic [31:0] branchOffset;
    logic [31:0] jalTarget;
    logic [31:0] branchTarget;
    logic [31:0] pcSelected;

    assign jalOffset = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
                        instr.jType.imm11, instr.jType.imm10to1, 1'b0};
    assign branchOffset = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                           instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};

    assign pcPlusFour   = pc + 32'd4;
    assign jalTarget    = pc + jalOffset;
    assign branchTarget = pc + branchOffset;

    always_comb begin
        case (pcSource)
            pcJal:    pcSelected = jalTarget;
            pcBranch: pcSelected = branchTarget;
            default:  pcSelected = pcPlusFour;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= pcSelected & pcMask;  // Wrap inside program memory
        end
    end

endmodule

//--- logic/riscvCore.sv
`timescale 1ns/1ns

module riscvCore #(
    parameter int programWords = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  corePkg::progLoadT progLoad,
    output corePkg::retireT   retire
);

    import isaPkg::*;
    import corePkg::*;

    instrT       instr;
    aluOpT       aluOp;
    pcSourceT    pcSource;
    logic [31:0] pc;
    logic [31:0] returnAddress;
    logic [31:0] rs1Value;
    logic [31:0] rs2Value;
    logic [31:0] immediate;
    logic [31:0] operandB;
    logic [31:0] aluResult;
    logic [31:0] writeData;
    logic        useImmediate;
    logic        decodedWrite;
    logic        isJal;
    logic        executing;
    logic        writeEnable;

    assign executing   = run && !reset;  // One instruction per active cycle
    assign writeEnable = decodedWrite && executing;
    assign operandB    = useImmediate ? immediate : rs2Value;
    assign writeData   = isJal ? returnAddress : aluResult;  // Link address for JAL

    instructionMemory #(.programWords(programWords)) instructionMemory_i (
        .clk      (clk),
        .progLoad (progLoad),
        .pc       (pc),
        .instr    (instr)
    );

    registerFile registerFile_i (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (writeEnable),
        .rd          (instr.rType.rd),
        .writeData   (writeData),
        .rs1         (instr.rType.rs1),
        .rs2         (instr.rType.rs2),
        .rs1Value    (rs1Value),
        .rs2Value    (rs2Value)
    );

    alu alu_i (
        .aluOp    (aluOp),
        .operandA (rs1Value),
        .operandB (operandB),
        .result   (aluResult)
    );

    decoder decoder_i (
        .instr        (instr),
        .aluResult    (aluResult),
        .aluOp        (aluOp),
        .useImmediate (useImmediate),
        .immediate    (immediate),
        .writeEnable  (decodedWrite),
        .isJal        (isJal),
        .pcSource     (pcSource)
    );

    nextPc #(.programWords(programWords)) nextPc_i (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .instr      (instr),
        .pcSource   (pcSource),
        .pc         (pc),
        .pcPlusFour (returnAddress)
    );

    // Trace of the instruction executing this cycle
    assign retire.valid       = executing;
    assign retire.pc          = pc;
    assign retire.instruction = instr;
    assign retire.rs1Value    = rs1Value;
    assign retire.rs2Value    = rs2Value;
    assign retire.writeEnable = writeEnable;
    assign retire.rd          = instr.rType.rd;
    assign retire.writeData   = writeData;

endmodule

//--- sim/riscvCore_asserts.sv
`timescale 1ns/1ns

module riscvCoreAsserts (
    input logic              clk,
    input logic              reset,
    input logic              run,
    input corePkg::progLoadT progLoad,
    input corePkg::retireT   retire
);

    import isaPkg::*;
    import corePkg::*;

    localparam logic [31:0] pcWrap = 32'hFF;  // 64 words of program

    int          errorCount = 0;
    logic [31:0] loadedWords [64];  // Image written through the load port
    logic [31:0] shadow [32];  // Last value written to each register
    logic        seenRetire;
    logic [31:0] expectedPc;
    logic [31:0] followingPc;
    logic [31:0] expectedWord;
    logic [31:0] shadowRs1;
    logic [31:0] shadowRs2;
    logic [31:0] word;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        isArith;
    logic        writesRd;

    function automatic logic compareHolds(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            f3Beq:   return a == b;
            f3Bne:   return a != b;
            f3Blt:   return $signed(a) < $signed(b);
            f3Bge:   return $signed(a) >= $signed(b);
            f3Bltu:  return a < b;
            f3Bgeu:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] aluExpected(input logic [31:0] w, input logic [31:0] a,
                                                input logic [31:0] b);
        logic [31:0] operand;
        logic        alt;
        operand = (w[6:0] == opOpImm) ? {{20{w[31]}}, w[31:20]} : b;
        alt     = w[30];
        case (w[14:12])
            f3AddSub: return (alt && w[6:0] == opOp) ? a - operand : a + operand;
            f3Sll:    return a << operand[4:0];
            f3Slt:    return {31'b0, $signed(a) < $signed(operand)};
            f3Sltu:   return {31'b0, a < operand};
            f3Xor:    return a ^ operand;
            f3SrlSra: return alt ? $unsigned($signed(a) >>> operand[4:0]) : a >> operand[4:0];
            f3Or:     return a | operand;
            default:  return a & operand;
        endcase
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            loadedWords[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (progLoad.valid) begin
            loadedWords[progLoad.wordAddress[5:0]] <= progLoad.data;
        end
    end

    assign word         = retire.instruction;
    assign rs1          = word[19:15];
    assign rs2          = word[24:20];
    assign isArith      = word[6:0] == opOp || word[6:0] == opOpImm;
    assign writesRd     = (isArith || word[6:0] == opJal) && retire.rd != 5'd0;
    assign expectedWord = loadedWords[retire.pc[7:2]];
    assign shadowRs1    = shadow[rs1];
    assign shadowRs2    = shadow[rs2];

    always_comb begin
        logic [31:0] jOffset;
        logic [31:0] bOffset;
        jOffset     = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        bOffset     = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        followingPc = retire.pc + 32'd4;
        if (word[6:0] == opJal) begin
            followingPc = retire.pc + jOffset;
        end else if (word[6:0] == opBranch
                     && compareHolds(word[14:12], retire.rs1Value, retire.rs2Value)) begin
            followingPc = retire.pc + bOffset;
        end
        followingPc = followingPc & pcWrap;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seenRetire <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (retire.valid) begin
            seenRetire <= 1'b1;
            expectedPc <= followingPc;
            if (writesRd) begin
                shadow[retire.rd] <= retire.writeData;
            end
        end
    end

    quietWhenIdle: assert property (@(posedge clk) (reset || !run) |-> !retire.valid)
        else begin
            errorCount++;
            $error("retire.valid was high during reset or while paused");
        end

    firstAtZero: assert property (@(posedge clk) disable iff (reset)
        retire.valid && !seenRetire |-> retire.pc == 32'd0)
        else begin
            errorCount++;
            $error("ERROR retire.pc %h expected 00000000", $sampled(retire.pc));
        end

    fetchMatches: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.instruction == expectedWord)
        else begin
            errorCount++;
            $error("ERROR retire.instruction %h expected %h", $sampled(retire.instruction),
                   $sampled(expectedWord));
        end

    // Covers sequential flow, JAL targets and branch outcomes
    controlFlow: assert property (@(posedge clk) disable iff (reset)
        retire.valid && seenRetire |-> retire.pc == expectedPc)
        else begin
            errorCount++;
            $error("ERROR retire.pc %h expected %h", $sampled(retire.pc), $sampled(expectedPc));
        end

    jalLink: assert property (@(posedge clk) disable iff (reset)
        retire.valid && word[6:0] == opJal && retire.rd != 5'd0
        |-> retire.writeEnable && retire.writeData == retire.pc + 32'd4)
        else begin
            errorCount++;
            $error("ERROR retire.writeData %h expected %h for JAL",
                   $sampled(retire.writeData), $sampled(retire.pc) + 32'd4);
        end

    aluResult: assert property (@(posedge clk) disable iff (reset)
        retire.valid && isArith && retire.rd != 5'd0
        |-> retire.writeEnable
            && retire.writeData == aluExpected(word, retire.rs1Value, retire.rs2Value))
        else begin
            errorCount++;
            $error("ERROR retire.writeData %h expected %h", $sampled(retire.writeData),
                   aluExpected($sampled(word), $sampled(retire.rs1Value),
                               $sampled(retire.rs2Value)));
        end

    rdZeroQuiet: assert property (@(posedge clk) disable iff (reset)
        retire.valid && retire.rd == 5'd0 |-> !retire.writeEnable)
        else begin
            errorCount++;
            $error("write enable was raised for destination x0");
        end

    // shadow[0] is never written, so x0 must read zero here too
    rs1Shadow: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.rs1Value == shadowRs1)
        else begin
            errorCount++;
            $error("ERROR retire.rs1Value %h expected %h for x%0d", $sampled(retire.rs1Value),
                   $sampled(shadowRs1), $sampled(rs1));
        end

    rs2Shadow: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.rs2Value == shadowRs2)
        else begin
            errorCount++;
            $error("ERROR retire.rs2Value %h expected %h for x%0d", $sampled(retire.rs2Value),
                   $sampled(shadowRs2), $sampled(rs2));
        end

endmodule

bind riscvCore riscvCoreAsserts riscvCoreAsserts_i (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .progLoad (progLoad),
    .retire   (retire)
);

//--- sim/coreTb.sv
`timescale 1ns/1ns

module coreTb;

    import isaPkg::*;
    import corePkg::*;

    localparam int programWords = 64;
    localparam int resetCycles  = 5;
    localparam int runCycles    = 400;
    localparam int cycleLimit   = resetCycles + programWords + runCycles + 50;

    logic     clk = 1'b0;
    logic     reset;
    logic     run;
    progLoadT progLoad;
    retireT   retire;

    integer      seed = 39519;
    int          cycleCount = 0;
    logic [31:0] programImage [programWords];
    int          aluKindCount [10] = '{default: 0};
    string       aluKindNames [10] = '{"add", "sll", "slt", "sltu", "xor",
                                       "srl", "or", "and", "sub", "sra"};
    int          takenCount = 0;
    int          notTakenCount = 0;
    int          jalCount = 0;
    int          reachErrors = 0;
    logic        lastWasBranch = 1'b0;
    logic [31:0] lastPc = '0;

    riscvCore #(.programWords(programWords)) riscvCore_i (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .progLoad (progLoad),
        .retire   (retire)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the run never reached its end", cycleCount);
            $display("sim failed");
            $finish;
        end
    end

    // ALU kinds 0 to 7 follow funct3, 8 is sub, 9 is sra
    task automatic makeProgram();
        logic [2:0]  branchF3 [6] = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
        int          aluKind;
        int          branchKind;
        int          pick;
        logic        alt;
        logic        useImm;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] bOff;
        logic [20:0] jOff;
        aluKind    = 0;
        branchKind = 0;
        for (int i = 0; i < programWords; i++) begin
            pick = {$random(seed)} % 8;
            rd   = 5'({$random(seed)} % 8);  // Only x0 to x7
            rs1  = 5'({$random(seed)} % 8);
            rs2  = 5'({$random(seed)} % 8);
            bOff = 13'(8 + 4 * ({$random(seed)} % 3));  // Forward skips, never +4
            jOff = 21'(8 + 4 * ({$random(seed)} % 3));
            if (pick < 5) begin
                f3     = (aluKind == 8) ? f3AddSub : (aluKind == 9) ? f3SrlSra : 3'(aluKind);
                alt    = aluKind >= 8;
                useImm = aluKind != 8 && ({$random(seed)} % 2 == 1);
                imm    = 12'($random(seed));
                if (f3 == f3Sll || f3 == f3SrlSra) begin
                    imm = {1'b0, alt, 5'b0, imm[4:0]};  // Shift amount form
                end
                if (useImm) begin
                    programImage[i] = {imm, rs1, f3, rd, opOpImm};
                end else begin
                    programImage[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opOp};
                end
                aluKind = (aluKind + 1) % 10;
            end else if (pick < 7) begin
                programImage[i] = {bOff[12], bOff[10:5], rs2, rs1, branchF3[branchKind],
                                   bOff[4:1], bOff[11], opBranch};
                branchKind = (branchKind + 1) % 6;
            end else begin
                programImage[i] = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, opJal};
            end
        end
    endtask

    // Sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        int         kind;
        logic [2:0] f3;
        if (retire.valid) begin
            f3 = retire.instruction[14:12];
            if (lastWasBranch) begin
                if (retire.pc == ((lastPc + 32'd4) & 32'hFF)) begin
                    notTakenCount++;
                end else begin
                    takenCount++;
                end
            end
            if (retire.instruction[6:0] == opOp || retire.instruction[6:0] == opOpImm) begin
                kind = int'(f3);
                if (retire.instruction[6:0] == opOp && f3 == f3AddSub && retire.instruction[30]) begin
                    kind = 8;
                end
                if (f3 == f3SrlSra && retire.instruction[30]) begin
                    kind = 9;
                end
                aluKindCount[kind]++;
            end
            if (retire.instruction[6:0] == opJal) begin
                jalCount++;
            end
            lastWasBranch = retire.instruction[6:0] == opBranch;
            lastPc        = retire.pc;
        end
    end

    task automatic checkReach();
        if (takenCount == 0) begin
            $display("no taken branch was executed");
            reachErrors++;
        end
        if (notTakenCount == 0) begin
            $display("no branch fell through without being taken");
            reachErrors++;
        end
        if (jalCount == 0) begin
            $display("no JAL was executed");
            reachErrors++;
        end
        for (int k = 0; k < 10; k++) begin
            if (aluKindCount[k] == 0) begin
                $display("no %s instruction was executed", aluKindNames[k]);
                reachErrors++;
            end
        end
    endtask

    initial begin
        int assertErrors;
        reset    <= 1'b1;
        run      <= 1'b0;
        progLoad <= '0;
        makeProgram();
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < programWords; i++) begin
            @(posedge clk);
            progLoad <= '{valid: 1'b1, wordAddress: 16'(i), data: programImage[i]};
        end
        @(posedge clk);
        progLoad <= '0;
        run      <= 1'b1;
        repeat (runCycles) @(posedge clk);
        run <= 1'b0;
        repeat (2) @(posedge clk);
        checkReach();
        assertErrors = riscvCore_i.riscvCoreAsserts_i.errorCount;
        $display("assertion errors: %0d, reach errors: %0d", assertErrors, reachErrors);
        if (assertErrors == 0 && reachErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/isaPkg.sv
logic/corePkg.sv
logic/instructionMemory.sv
logic/registerFile.sv
logic/alu.sv
logic/decoder.sv
logic/nextPc.sv
logic/riscvCore.sv
sim/riscvCore_asserts.sv
sim/coreTb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = coreTb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log
VFLAGS     = --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only -Wall --timing --assert --top-module $(TOP)
RUN_FLAGS  = +verilator+error+limit+1000
PASS_TEXT  = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
